// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_soc_harness
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Something failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/addr_decode.sv ====
/*
 * Address map decoder
 * Matches a bus address against the harness regions and registers a
 * one-hot slave select together with a decode error flag.
 */

`timescale 1ns/1ps
`default_nettype none

module addr_decode (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                addr_valid_i,
  input  logic [soc_cfg_pkg::AddrWidth-1:0]   addr_i,
  output logic [soc_cfg_pkg::NrSlaves-1:0]    slave_sel_o,
  output logic                                decode_err_o
);

  import soc_cfg_pkg::*;

  logic [NrSlaves-1:0] match;

  // offset compare, an address below base wraps and misses
  function automatic logic in_region(
    input logic [AddrWidth-1:0] addr,
    input logic [AddrWidth-1:0] base,
    input logic [AddrWidth-1:0] len
  );
    logic [AddrWidth-1:0] offset;
    offset = addr - base;
    return offset < len;
  endfunction

  always_comb begin
    match = '0;
    for (int unsigned i = 0; i < NrSlaves; i++) begin
      match[i] = in_region(addr_i, RegionBase[i], RegionLength[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slave_sel_o  <= '0;
      decode_err_o <= 1'b0;
    end else begin
      slave_sel_o  <= addr_valid_i ? match : '0;
      decode_err_o <= addr_valid_i && (match == '0);
    end
  end

endmodule

`default_nettype wire

// ==== design/dbg_pkg.sv ====
/*
 * Debug module interface definitions
 * Field widths and operation encoding of DMI requests and responses.
 */

`default_nettype none

package dbg_pkg;

  // register address and data of a DMI access
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;

  // response code width, 0 means success
  localparam int unsigned DmiRespWidth = 2;

  // DMI operation, same encoding as the DTM op field
  typedef enum logic [1:0] {
    DmiOpNop   = 2'h0,
    DmiOpRead  = 2'h1,
    DmiOpWrite = 2'h2
  } dmi_op_e;

endpackage

`default_nettype wire

// ==== design/debug_req_gate.sv ====
/*
 * Debug request gate
 * Holds off debug requests to the core during the boot window after
 * power-on reset, and whenever debugging is disabled.
 */

`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_enable_i,
  input  logic dm_debug_req_i,
  output logic core_debug_req_o
);

  import soc_cfg_pkg::*;

  logic [$clog2(DmiDelCycles+1)-1:0] del_cnt_d;
  logic [$clog2(DmiDelCycles+1)-1:0] del_cnt_q;

  // count down to zero and stay there
  assign del_cnt_d = (del_cnt_q != '0) ? del_cnt_q - 1'b1 : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= DmiDelCycles[$clog2(DmiDelCycles+1)-1:0];
    end else begin
      del_cnt_q <= del_cnt_d;
    end
  end

  // boot code runs undisturbed until the window closes
  assign core_debug_req_o = (del_cnt_q == '0) && debug_enable_i && dm_debug_req_i;

endmodule

`default_nettype wire

// ==== design/dmi_mux.sv ====
/*
 * DMI source multiplexer
 * Connects either the JTAG transport or the simulated DTM to the
 * debug module, steering response valid back to the active source.
 */

`timescale 1ns/1ps
`default_nettype none

module dmi_mux (
  input  logic                               jtag_sel_i,
  // JTAG source
  input  logic                               jtag_req_valid_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]   jtag_req_addr_i,
  input  dbg_pkg::dmi_op_e                   jtag_req_op_i,
  input  logic [dbg_pkg::DmiDataWidth-1:0]   jtag_req_data_i,
  input  logic                               jtag_resp_ready_i,
  output logic                               jtag_resp_valid_o,
  // simulated DTM source
  input  logic                               dtm_req_valid_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]   dtm_req_addr_i,
  input  dbg_pkg::dmi_op_e                   dtm_req_op_i,
  input  logic [dbg_pkg::DmiDataWidth-1:0]   dtm_req_data_i,
  input  logic                               dtm_resp_ready_i,
  output logic                               dtm_resp_valid_o,
  // debug module side
  output logic                               dm_req_valid_o,
  output logic [dbg_pkg::DmiAddrWidth-1:0]   dm_req_addr_o,
  output dbg_pkg::dmi_op_e                   dm_req_op_o,
  output logic [dbg_pkg::DmiDataWidth-1:0]   dm_req_data_o,
  output logic                               dm_resp_ready_o,
  input  logic                               dm_resp_valid_i
);

  import dbg_pkg::*;

  // request channel follows the selected source
  assign dm_req_valid_o  = jtag_sel_i ? jtag_req_valid_i  : dtm_req_valid_i;
  assign dm_req_addr_o   = jtag_sel_i ? jtag_req_addr_i   : dtm_req_addr_i;
  assign dm_req_op_o     = jtag_sel_i ? jtag_req_op_i     : dtm_req_op_i;
  assign dm_req_data_o   = jtag_sel_i ? jtag_req_data_i   : dtm_req_data_i;
  assign dm_resp_ready_o = jtag_sel_i ? jtag_resp_ready_i : dtm_resp_ready_i;

  // idle source never sees a response
  assign jtag_resp_valid_o = jtag_sel_i ? dm_resp_valid_i : 1'b0;
  assign dtm_resp_valid_o  = jtag_sel_i ? 1'b0            : dm_resp_valid_i;

endmodule

`default_nettype wire

// ==== design/irq_route.sv ====
/*
 * Local interrupt router
 * Assembles the local interrupt vector and registers the request,
 * the highest pending id and its one-hot form for the core.
 */

`timescale 1ns/1ps
`default_nettype none

module irq_route (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                meip_i,
  input  logic                                seip_i,
  input  logic                                mtip_i,
  input  logic [soc_cfg_pkg::NumExtIrq-1:0]   ext_irq_i,
  output logic                                irq_req_o,
  output logic [soc_cfg_pkg::IrqIdWidth-1:0]  irq_id_o,
  output logic [soc_cfg_pkg::NumLocalIrq-1:0] irq_onehot_o
);

  import soc_cfg_pkg::*;

  logic [NumLocalIrq-1:0] irq_vec;
  logic                   irq_req;
  logic [IrqIdWidth-1:0]  irq_id;
  logic [NumLocalIrq-1:0] irq_onehot;

  // fixed positions, everything else reserved
  always_comb begin
    irq_vec                                = '0;
    irq_vec[MtipBit]                       = mtip_i;
    irq_vec[SeipBit]                       = seip_i;
    irq_vec[MeipBit]                       = meip_i;
    irq_vec[NumLocalIrq-1 -: NumExtIrq]    = ext_irq_i;
  end

  // highest index wins, so scan upwards and keep the last hit
  always_comb begin
    irq_id = '0;
    for (int unsigned i = 0; i < NumLocalIrq; i++) begin
      if (irq_vec[i]) begin
        irq_id = IrqIdWidth'(i);
      end
    end
  end

  assign irq_req = |irq_vec;

  always_comb begin
    irq_onehot = '0;
    if (irq_req) begin
      irq_onehot[irq_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_req_o    <= 1'b0;
      irq_id_o     <= '0;
      irq_onehot_o <= '0;
    end else begin
      irq_req_o    <= irq_req;
      irq_id_o     <= irq_id;
      irq_onehot_o <= irq_onehot;
    end
  end

endmodule

`default_nettype wire

// ==== design/rst_sync.sv ====
/*
 * System reset synchronizer
 * Asserts asynchronously on power-on reset or debug non-dm reset and
 * releases synchronously through a short flop chain.
 */

`timescale 1ns/1ps
`default_nettype none

module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic                                    rst_comb_n;
  logic [soc_cfg_pkg::RstSyncStages-1:0] sync_q;

  // either source pulls the system into reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[soc_cfg_pkg::RstSyncStages-2:0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[soc_cfg_pkg::RstSyncStages-1];

endmodule

`default_nettype wire

// ==== design/soc_cfg_pkg.sv ====
/*
 * SoC harness configuration
 * Address map, reset synchronizer depth, debug boot window and
 * local interrupt layout shared by the harness glue logic.
 */

`default_nettype none

package soc_cfg_pkg;

  // ---------------------------------------------------------------------------
  // address map
  // ---------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned NrSlaves  = 4;

  localparam int unsigned SlvDebug = 0;
  localparam int unsigned SlvRom   = 1;
  localparam int unsigned SlvClint = 2;
  localparam int unsigned SlvDram  = 3;

  // start inclusive, base + length exclusive
  localparam logic [AddrWidth-1:0] DebugBase   = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] DebugLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h000C_0000;
  localparam logic [AddrWidth-1:0] DramBase    = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength  = 32'h4000_0000;

  // region tables, indexed by slave index
  localparam logic [NrSlaves-1:0][AddrWidth-1:0] RegionBase =
    {DramBase, ClintBase, RomBase, DebugBase};
  localparam logic [NrSlaves-1:0][AddrWidth-1:0] RegionLength =
    {DramLength, ClintLength, RomLength, DebugLength};

  // ---------------------------------------------------------------------------
  // reset and debug timing
  // ---------------------------------------------------------------------------
  localparam int unsigned RstSyncStages = 2;
  localparam int unsigned DmiDelCycles  = 16;

  // ---------------------------------------------------------------------------
  // local interrupts
  // ---------------------------------------------------------------------------
  localparam int unsigned NumLocalIrq = 16;
  localparam int unsigned IrqIdWidth  = 4;
  // platform lines sit at the top of the vector
  localparam int unsigned NumExtIrq   = 4;
  localparam int unsigned MtipBit     = 7;
  localparam int unsigned SeipBit     = 9;
  localparam int unsigned MeipBit     = 11;

endpackage

`default_nettype wire

// ==== design/soc_harness_top.sv ====
/*
 * SoC test harness glue
 * Reset generation, DMI source selection, debug request gating,
 * address decoding and local interrupt routing for a RISC-V core.
 */

`timescale 1ns/1ps
`default_nettype none

module soc_harness_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                ndmreset_i,
  input  logic                                jtag_sel_i,
  input  logic                                debug_enable_i,
  input  logic                                dm_debug_req_i,
  // JTAG DMI source
  input  logic                                jtag_req_valid_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]    jtag_req_addr_i,
  input  dbg_pkg::dmi_op_e                    jtag_req_op_i,
  input  logic [dbg_pkg::DmiDataWidth-1:0]    jtag_req_data_i,
  input  logic                                jtag_resp_ready_i,
  output logic                                jtag_resp_valid_o,
  // DTM DMI source
  input  logic                                dtm_req_valid_i,
  input  logic [dbg_pkg::DmiAddrWidth-1:0]    dtm_req_addr_i,
  input  dbg_pkg::dmi_op_e                    dtm_req_op_i,
  input  logic [dbg_pkg::DmiDataWidth-1:0]    dtm_req_data_i,
  input  logic                                dtm_resp_ready_i,
  output logic                                dtm_resp_valid_o,
  // debug module DMI side
  output logic                                dm_req_valid_o,
  output logic [dbg_pkg::DmiAddrWidth-1:0]    dm_req_addr_o,
  output dbg_pkg::dmi_op_e                    dm_req_op_o,
  output logic [dbg_pkg::DmiDataWidth-1:0]    dm_req_data_o,
  output logic                                dm_resp_ready_o,
  input  logic                                dm_resp_valid_i,
  // bus address
  input  logic                                addr_valid_i,
  input  logic [soc_cfg_pkg::AddrWidth-1:0]   addr_i,
  // interrupt lines
  input  logic                                meip_i,
  input  logic                                seip_i,
  input  logic                                mtip_i,
  input  logic [soc_cfg_pkg::NumExtIrq-1:0]   ext_irq_i,
  // outputs
  output logic                                sys_rst_no,
  output logic                                core_debug_req_o,
  output logic [soc_cfg_pkg::NrSlaves-1:0]    slave_sel_o,
  output logic                                decode_err_o,
  output logic                                irq_req_o,
  output logic [soc_cfg_pkg::IrqIdWidth-1:0]  irq_id_o,
  output logic [soc_cfg_pkg::NumLocalIrq-1:0] irq_onehot_o
);

  import soc_cfg_pkg::*;
  import dbg_pkg::*;

  // ---------------------------------------------------------------------------
  // reset
  // ---------------------------------------------------------------------------
  rst_sync i_rst_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_no )
  );

  // ---------------------------------------------------------------------------
  // debug
  // ---------------------------------------------------------------------------
  dmi_mux i_dmi_mux (
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_addr_i   ( jtag_req_addr_i   ),
    .jtag_req_op_i     ( jtag_req_op_i     ),
    .jtag_req_data_i   ( jtag_req_data_i   ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_addr_i    ( dtm_req_addr_i    ),
    .dtm_req_op_i      ( dtm_req_op_i      ),
    .dtm_req_data_i    ( dtm_req_data_i    ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dm_req_valid_o    ( dm_req_valid_o    ),
    .dm_req_addr_o     ( dm_req_addr_o     ),
    .dm_req_op_o       ( dm_req_op_o       ),
    .dm_req_data_o     ( dm_req_data_o     ),
    .dm_resp_ready_o   ( dm_resp_ready_o   ),
    .dm_resp_valid_i   ( dm_resp_valid_i   )
  );

  // boot window counts from power-on reset, not from ndmreset
  debug_req_gate i_debug_req_gate (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .debug_enable_i   ( debug_enable_i   ),
    .dm_debug_req_i   ( dm_debug_req_i   ),
    .core_debug_req_o ( core_debug_req_o )
  );

  // ---------------------------------------------------------------------------
  // address map and interrupts, system reset domain
  // ---------------------------------------------------------------------------
  addr_decode i_addr_decode (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_no   ),
    .addr_valid_i ( addr_valid_i ),
    .addr_i       ( addr_i       ),
    .slave_sel_o  ( slave_sel_o  ),
    .decode_err_o ( decode_err_o )
  );

  irq_route i_irq_route (
    .clk_i        ( clk_i        ),
    .rst_ni       ( sys_rst_no   ),
    .meip_i       ( meip_i       ),
    .seip_i       ( seip_i       ),
    .mtip_i       ( mtip_i       ),
    .ext_irq_i    ( ext_irq_i    ),
    .irq_req_o    ( irq_req_o    ),
    .irq_id_o     ( irq_id_o     ),
    .irq_onehot_o ( irq_onehot_o )
  );

endmodule

`default_nettype wire

// ==== files.f ====
design/soc_cfg_pkg.sv
design/dbg_pkg.sv
design/rst_sync.sv
design/dmi_mux.sv
design/debug_req_gate.sv
design/addr_decode.sv
design/irq_route.sv
design/soc_harness_top.sv
testbench/tb_clock.sv
testbench/soc_harness_asserts.sv
testbench/tb_soc_harness.sv

// ==== testbench/soc_harness_asserts.sv ====
/*
 * SoC harness assertions
 * Checks select and interrupt encodings on the harness outputs.
 */

`timescale 1ns/1ps
`default_nettype none

module soc_harness_asserts (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic [soc_cfg_pkg::NrSlaves-1:0]    slave_sel_i,
  input logic                                decode_err_i,
  input logic                                irq_req_i,
  input logic [soc_cfg_pkg::NumLocalIrq-1:0] irq_onehot_i
);

  // at most one region selected
  sel_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(slave_sel_i))
    else $error("slave select has more than one bit set");

  // a miss never carries a select
  err_no_sel_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    decode_err_i |-> (slave_sel_i == '0))
    else $error("decode error together with a slave select");

  // one-hot follows the request flag
  irq_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(irq_onehot_i) && ((irq_onehot_i != '0) == irq_req_i))
    else $error("interrupt one-hot does not match the request");

endmodule

bind soc_harness_top soc_harness_asserts i_soc_harness_asserts (
  .clk_i        ( clk_i        ),
  .rst_ni       ( sys_rst_no   ),
  .slave_sel_i  ( slave_sel_o  ),
  .decode_err_i ( decode_err_o ),
  .irq_req_i    ( irq_req_o    ),
  .irq_onehot_i ( irq_onehot_o )
);

`default_nettype wire

// ==== testbench/tb_clock.sv ====
/*
 * Testbench clock source
 * Free-running clock with a configurable half period.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int unsigned HalfPeriodNs = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_soc_harness.sv ====
/*
 * Testbench for the SoC harness glue
 * Directed and table-driven checks of reset, DMI selection, debug
 * gating, address decoding and interrupt routing.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_soc_harness;

  import soc_cfg_pkg::*;
  import dbg_pkg::*;

  localparam int unsigned ClkPeriodNs    = 20;
  localparam int unsigned ResetCycles    = 10;
  localparam int unsigned NumDmi         = 4;
  localparam int unsigned NumAddr        = 14;
  localparam int unsigned NumIrqDir      = 7;
  localparam int unsigned NumIrqRnd      = 20;
  localparam int unsigned WatchdogCycles =
    4 * (NumDmi + NumAddr + NumIrqDir + NumIrqRnd + DmiDelCycles + ResetCycles);

  // columns: addr_valid, addr, decode error, slave select
  localparam logic [37:0] AddrTbl [NumAddr] = '{
    {1'b1, 32'h0000_0000, 5'b0_0001},
    {1'b1, 32'h0000_0FFF, 5'b0_0001},
    {1'b1, 32'h0000_1000, 5'b1_0000},
    {1'b1, 32'h0001_0000, 5'b0_0010},
    {1'b1, 32'h0001_FFFF, 5'b0_0010},
    {1'b1, 32'h0002_0000, 5'b1_0000},
    {1'b1, 32'h0200_0000, 5'b0_0100},
    {1'b1, 32'h020B_FFFF, 5'b0_0100},
    {1'b1, 32'h020C_0000, 5'b1_0000},
    {1'b1, 32'h8000_0000, 5'b0_1000},
    {1'b1, 32'hBFFF_FFFF, 5'b0_1000},
    {1'b1, 32'hC000_0000, 5'b1_0000},
    // hole between clint and dram
    {1'b1, 32'h4000_0000, 5'b1_0000},
    {1'b0, 32'h8000_0000, 5'b0_0000}
  };

  // columns: meip, seip, mtip, ext_irq[3:0]
  localparam logic [6:0] IrqTbl [NumIrqDir] = '{
    7'b000_0000,
    7'b001_0000,
    7'b110_0000,
    7'b000_0001,
    7'b000_0010,
    7'b000_0100,
    7'b000_1000
  };

  // DUT signals, named like the ports
  logic clk_i, rst_ni, ndmreset_i, jtag_sel_i, debug_enable_i, dm_debug_req_i;
  logic jtag_req_valid_i, jtag_resp_ready_i, jtag_resp_valid_o;
  logic dtm_req_valid_i, dtm_resp_ready_i, dtm_resp_valid_o;
  logic dm_req_valid_o, dm_resp_ready_o, dm_resp_valid_i;
  logic [DmiAddrWidth-1:0] jtag_req_addr_i, dtm_req_addr_i, dm_req_addr_o;
  logic [DmiDataWidth-1:0] jtag_req_data_i, dtm_req_data_i, dm_req_data_o;
  dmi_op_e                 jtag_req_op_i, dtm_req_op_i, dm_req_op_o;
  logic                    addr_valid_i, meip_i, seip_i, mtip_i;
  logic [AddrWidth-1:0]    addr_i;
  logic [NumExtIrq-1:0]    ext_irq_i;
  logic                    sys_rst_no, core_debug_req_o, decode_err_o, irq_req_o;
  logic [NrSlaves-1:0]     slave_sel_o;
  logic [IrqIdWidth-1:0]   irq_id_o;
  logic [NumLocalIrq-1:0]  irq_onehot_o;

  int unsigned n_tests;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned test_checks;
  int unsigned test_errors;
  logic [31:0] rnd;

  tb_clock #(.HalfPeriodNs(ClkPeriodNs / 2)) i_tb_clock (.clk_o(clk_i));

  soc_harness_top i_soc_harness_top (.*);

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------
  task automatic step_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    n_tests++;
    n_checks += test_checks;
    n_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic run_addr_row(input logic [37:0] row);
    addr_valid_i = row[37];
    addr_i       = row[36:5];
    step_cycle();
    check_value("slave_sel_o", 32'(slave_sel_o), 32'(row[3:0]));
    check_value("decode_err_o", 32'(decode_err_o), 32'(row[4]));
  endtask

  task automatic run_irq_pattern(input logic [6:0] pat);
    logic [NumLocalIrq-1:0] vec;
    logic [NumLocalIrq-1:0] exp_onehot;
    int                     exp_id;
    logic                   found;
    meip_i    = pat[6];
    seip_i    = pat[5];
    mtip_i    = pat[4];
    ext_irq_i = pat[3:0];
    vec                             = '0;
    vec[MtipBit]                    = pat[4];
    vec[SeipBit]                    = pat[5];
    vec[MeipBit]                    = pat[6];
    vec[NumLocalIrq-1 -: NumExtIrq] = pat[3:0];
    // search from the top, first hit is the winner
    exp_id     = 0;
    found      = 1'b0;
    exp_onehot = '0;
    for (int i = NumLocalIrq - 1; i >= 0; i--) begin
      if (!found && vec[i]) begin
        exp_id = i;
        found  = 1'b1;
      end
    end
    if (found) begin
      exp_onehot[exp_id] = 1'b1;
    end
    step_cycle();
    check_value("irq_req_o", 32'(irq_req_o), 32'(found));
    check_value("irq_id_o", 32'(irq_id_o), exp_id);
    check_value("irq_onehot_o", 32'(irq_onehot_o), 32'(exp_onehot));
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------
  initial begin
    rst_ni            = 1'b0;
    ndmreset_i        = 1'b0;
    jtag_sel_i        = 1'b0;
    debug_enable_i    = 1'b1;
    dm_debug_req_i    = 1'b1;
    jtag_req_valid_i  = 1'b0;
    jtag_req_addr_i   = '0;
    jtag_req_op_i     = DmiOpNop;
    jtag_req_data_i   = '0;
    jtag_resp_ready_i = 1'b0;
    dtm_req_valid_i   = 1'b0;
    dtm_req_addr_i    = '0;
    dtm_req_op_i      = DmiOpNop;
    dtm_req_data_i    = '0;
    dtm_resp_ready_i  = 1'b0;
    dm_resp_valid_i   = 1'b0;
    addr_valid_i      = 1'b0;
    addr_i            = '0;
    meip_i            = 1'b0;
    seip_i            = 1'b0;
    mtip_i            = 1'b0;
    ext_irq_i         = '0;
    n_tests           = 0;
    n_checks          = 0;
    n_errors          = 0;
    test_checks       = 0;
    test_errors       = 0;

    repeat (ResetCycles) step_cycle();
    rst_ni = 1'b1;
    #1;
    check_value("sys_rst_no", 32'(sys_rst_no), 32'(1'b0));
    check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(1'b0));
    // sync release and boot window run from the same edge
    for (int unsigned k = 1; k <= DmiDelCycles; k++) begin
      step_cycle();
      check_value("sys_rst_no", 32'(sys_rst_no), 32'(k >= RstSyncStages));
      check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(k >= DmiDelCycles));
    end
    end_test("reset and boot window");

    ndmreset_i = 1'b1;
    #1;
    check_value("sys_rst_no", 32'(sys_rst_no), 32'(1'b0));
    step_cycle();
    ndmreset_i = 1'b0;
    step_cycle();
    check_value("sys_rst_no", 32'(sys_rst_no), 32'(1'b0));
    step_cycle();
    check_value("sys_rst_no", 32'(sys_rst_no), 32'(1'b1));
    // debug gate lives in the power-on domain
    check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(1'b1));
    end_test("ndmreset");

    debug_enable_i = 1'b0;
    #1;
    check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(1'b0));
    step_cycle();
    check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(1'b0));
    debug_enable_i = 1'b1;
    #1;
    check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(1'b1));
    step_cycle();
    // open window, output follows the debug module request
    dm_debug_req_i = 1'b0;
    #1;
    check_value("core_debug_req_o", 32'(core_debug_req_o), 32'(1'b0));
    step_cycle();
    dm_debug_req_i = 1'b1;
    end_test("debug enable");

    jtag_req_addr_i = 7'h11;
    jtag_req_op_i   = DmiOpRead;
    jtag_req_data_i = 32'hA5A5_0001;
    dtm_req_addr_i  = 7'h38;
    dtm_req_op_i    = DmiOpWrite;
    dtm_req_data_i  = 32'h5A5A_0002;
    for (int i = 0; i < NumDmi; i++) begin
      jtag_sel_i        = i[1];
      jtag_req_valid_i  = i[0];
      dtm_req_valid_i   = !i[0];
      jtag_resp_ready_i = i[0];
      dtm_resp_ready_i  = !i[0];
      dm_resp_valid_i   = i[0] ^ i[1];
      #1;
      if (jtag_sel_i) begin
        check_value("dm_req_valid_o", 32'(dm_req_valid_o), 32'(jtag_req_valid_i));
        check_value("dm_req_addr_o", 32'(dm_req_addr_o), 32'(jtag_req_addr_i));
        check_value("dm_req_op_o", 32'(dm_req_op_o), 32'(jtag_req_op_i));
        check_value("dm_req_data_o", dm_req_data_o, jtag_req_data_i);
        check_value("dm_resp_ready_o", 32'(dm_resp_ready_o), 32'(jtag_resp_ready_i));
      end else begin
        check_value("dm_req_valid_o", 32'(dm_req_valid_o), 32'(dtm_req_valid_i));
        check_value("dm_req_addr_o", 32'(dm_req_addr_o), 32'(dtm_req_addr_i));
        check_value("dm_req_op_o", 32'(dm_req_op_o), 32'(dtm_req_op_i));
        check_value("dm_req_data_o", dm_req_data_o, dtm_req_data_i);
        check_value("dm_resp_ready_o", 32'(dm_resp_ready_o), 32'(dtm_resp_ready_i));
      end
      check_value("jtag_resp_valid_o", 32'(jtag_resp_valid_o),
                  32'(jtag_sel_i && dm_resp_valid_i));
      check_value("dtm_resp_valid_o", 32'(dtm_resp_valid_o),
                  32'(!jtag_sel_i && dm_resp_valid_i));
      step_cycle();
    end
    dm_resp_valid_i  = 1'b0;
    jtag_req_valid_i = 1'b0;
    dtm_req_valid_i  = 1'b0;
    end_test("dmi select");

    for (int i = 0; i < NumAddr; i++) begin
      run_addr_row(AddrTbl[i]);
    end
    end_test("address decode");

    for (int i = 0; i < NumIrqDir; i++) begin
      run_irq_pattern(IrqTbl[i]);
    end
    rnd = 32'h2d7d;
    for (int i = 0; i < NumIrqRnd; i++) begin
      rnd = xorshift32(rnd);
      run_irq_pattern(rnd[6:0]);
    end
    end_test("interrupt routing");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WatchdogCycles * ClkPeriodNs);
    $display("timeout: run did not finish within %0d clock cycles", WatchdogCycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
